// ==== hdl/alu_defs_pkg.sv ====
// Data width, function-vector bit positions, operand and request types for the ALU datapath.
`default_nettype none

package alu_defs_pkg;

    localparam int XLEN    = 32;
    localparam int SHAMT_W = 5;

    typedef logic [XLEN-1:0] alu_data_t;

    // one-hot function vector layout.
    localparam int FN_ADD   = 0;
    localparam int FN_SUB   = 1;
    localparam int FN_SLT   = 2;
    localparam int FN_SLTU  = 3;
    localparam int FN_AND   = 4;
    localparam int FN_OR    = 5;
    localparam int FN_XOR   = 6;
    localparam int FN_SLL   = 7;
    localparam int FN_SRL   = 8;
    localparam int FN_SRA   = 9;
    localparam int FN_LEA   = 10;
    localparam int FN_BFEXT = 11;
    localparam int FUNC_W   = 12;

    typedef logic [FUNC_W-1:0] alu_func_t;

    // field bounds for bit-field extract sit in operand b at these positions.
    localparam int BF_LSB_POS = 0;
    localparam int BF_MSB_POS = 6;

    typedef struct packed {
        alu_data_t op_a;
        alu_data_t op_b;
        alu_func_t func;
        logic      logic_inv;
        logic [1:0] scale;
        logic      bf_signed;
    } alu_req_t;

endpackage

`default_nettype wire

// ==== hdl/alu_isa_pkg.sv ====
// Operation codes accepted at the execute unit boundary.
`default_nettype none

package alu_isa_pkg;

    typedef enum logic [4:0] {
        ADD    = 5'd0,
        SUB    = 5'd1,
        SLT    = 5'd2,
        SLTU   = 5'd3,
        AND    = 5'd4,
        OR     = 5'd5,
        XOR    = 5'd6,
        ANDN   = 5'd7,
        ORN    = 5'd8,
        XNOR   = 5'd9,
        SLL    = 5'd10,
        SRL    = 5'd11,
        SRA    = 5'd12,
        // scaled-index adds, operand b shifted left by 1, 2 or 3.
        LEA1   = 5'd13,
        LEA2   = 5'd14,
        LEA3   = 5'd15,
        BFEXTU = 5'd16,
        BFEXT  = 5'd17
    } alu_opcode_t;

endpackage

`default_nettype wire

// ==== hdl/alu_req_if.sv ====
// Decoded request bus between the decode pipe stage and the ALU.
`timescale 1ns/1ps
`default_nettype none

interface alu_req_if;
    import alu_defs_pkg::*;

    logic       valid;
    alu_data_t  op_a;
    alu_data_t  op_b;
    alu_func_t  func;
    logic       logic_inv;
    logic [1:0] scale;
    logic       bf_signed;

    modport src (
        output valid, op_a, op_b, func, logic_inv, scale, bf_signed
    );

    modport sink (
        input valid, op_a, op_b, func, logic_inv, scale, bf_signed
    );

endinterface

`default_nettype wire

// ==== hdl/alu_op_decode.sv ====
// Opcode decoder producing the one-hot function vector and the ALU control bits.
`timescale 1ns/1ps
`default_nettype none

module alu_op_decode #(
    parameter bit LEA_EN = 1'b1,
    parameter bit BFO_EN = 1'b1
) (
    input  alu_isa_pkg::alu_opcode_t opcode,
    input  alu_defs_pkg::alu_data_t  op_a,
    input  alu_defs_pkg::alu_data_t  op_b,
    output alu_defs_pkg::alu_req_t   req
);
    import alu_defs_pkg::*;
    import alu_isa_pkg::*;

    always_comb begin
        req      = '0;
        req.op_a = op_a;
        req.op_b = op_b;
        case (opcode)
            ADD:  req.func[FN_ADD]  = 1'b1;
            SUB:  req.func[FN_SUB]  = 1'b1;
            SLT:  req.func[FN_SLT]  = 1'b1;
            SLTU: req.func[FN_SLTU] = 1'b1;
            AND:  req.func[FN_AND]  = 1'b1;
            OR:   req.func[FN_OR]   = 1'b1;
            XOR:  req.func[FN_XOR]  = 1'b1;
            ANDN: begin
                req.func[FN_AND] = 1'b1;
                req.logic_inv    = 1'b1;
            end
            ORN: begin
                req.func[FN_OR] = 1'b1;
                req.logic_inv   = 1'b1;
            end
            XNOR: begin
                req.func[FN_XOR] = 1'b1;
                req.logic_inv    = 1'b1;
            end
            SLL:  req.func[FN_SLL] = 1'b1;
            SRL:  req.func[FN_SRL] = 1'b1;
            SRA:  req.func[FN_SRA] = 1'b1;
            LEA1, LEA2, LEA3: begin
                if (LEA_EN) begin
                    req.func[FN_LEA] = 1'b1;
                    // the low two opcode bits happen to encode the scale.
                    req.scale = (opcode == LEA1) ? 2'd1 :
                                (opcode == LEA2) ? 2'd2 : 2'd3;
                end
            end
            BFEXTU, BFEXT: begin
                if (BFO_EN) begin
                    req.func[FN_BFEXT] = 1'b1;
                    req.bf_signed      = (opcode == BFEXT);
                end
            end
            default: begin
                // Unknown codes leave every flag clear, so the result is zero.
                req.func = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/alu_core.sv ====
// Combinational ALU with adder, compare, shifter, logic, scaled-add and bit-field paths.
`timescale 1ns/1ps
`default_nettype none

module alu_core #(
    parameter bit LEA_EN = 1'b1,
    parameter bit BFO_EN = 1'b1
) (
    alu_req_if.sink                 req,
    output alu_defs_pkg::alu_data_t result_next
);
    import alu_defs_pkg::*;

    function automatic alu_data_t bit_reverse(input alu_data_t x);
        alu_data_t r;
        for (int i = 0; i < XLEN; i++) begin
            r[i] = x[XLEN-1-i];
        end
        return r;
    endfunction

    alu_func_t f;
    assign f = req.func;

    // compares share the subtracting adder.
    logic          use_sub;
    alu_data_t     add_b;
    logic [XLEN:0] sum;
    logic          lt_u;
    logic          lt_s;

    assign use_sub = f[FN_SUB] | f[FN_SLT] | f[FN_SLTU];
    assign add_b   = req.op_b ^ {XLEN{use_sub}};
    assign sum     = {1'b0, req.op_a} + {1'b0, add_b} + {{XLEN{1'b0}}, use_sub};
    assign lt_u    = ~sum[XLEN];
    assign lt_s    = (req.op_a[XLEN-1] & ~req.op_b[XLEN-1]) |
                     ((req.op_a[XLEN-1] == req.op_b[XLEN-1]) & sum[XLEN-1]);

    // Left shifts run through the right shifter with the bits reversed on both sides.
    logic [SHAMT_W-1:0] shamt;
    alu_data_t          sh_in;
    logic               sh_fill;
    logic [2*XLEN-1:0]  sh_ext;
    alu_data_t          sh_raw;
    alu_data_t          sh_res;

    assign shamt   = req.op_b[SHAMT_W-1:0];
    assign sh_in   = f[FN_SLL] ? bit_reverse(req.op_a) : req.op_a;
    assign sh_fill = f[FN_SRA] & req.op_a[XLEN-1];
    assign sh_ext  = {{XLEN{sh_fill}}, sh_in} >> shamt;
    assign sh_raw  = sh_ext[XLEN-1:0];
    assign sh_res  = f[FN_SLL] ? bit_reverse(sh_raw) : sh_raw;

    alu_data_t logic_b;
    alu_data_t and_res;
    alu_data_t or_res;
    alu_data_t xor_res;

    assign logic_b = req.op_b ^ {XLEN{req.logic_inv}};
    assign and_res = req.op_a & logic_b;
    assign or_res  = req.op_a | logic_b;
    assign xor_res = req.op_a ^ logic_b;

    alu_data_t lea_res;
    alu_data_t bf_res;

    generate
        if (LEA_EN) begin : gen_lea
            assign lea_res = req.op_a + (req.op_b << req.scale);
        end else begin : gen_no_lea
            assign lea_res = '0;
        end
    endgenerate

    generate
        if (BFO_EN) begin : gen_bfext
            logic [SHAMT_W-1:0] lsb;
            logic [SHAMT_W-1:0] msb;
            logic [SHAMT_W-1:0] span;
            alu_data_t          mask;
            alu_data_t          field;
            logic               sign;

            assign lsb   = req.op_b[BF_LSB_POS +: SHAMT_W];
            assign msb   = req.op_b[BF_MSB_POS +: SHAMT_W];
            assign span  = msb - lsb;
            // span + 1 ones at the bottom of the word.
            assign mask  = {XLEN{1'b1}} >> ~span;
            assign field = req.op_a >> lsb;
            assign sign  = req.bf_signed & req.op_a[msb];
            assign bf_res = (msb < lsb) ? '0 : ((field & mask) | (~mask & {XLEN{sign}}));
        end else begin : gen_no_bfext
            assign bf_res = '0;
        end
    endgenerate

    assign result_next = ({XLEN{f[FN_ADD] | f[FN_SUB]}} & sum[XLEN-1:0])
                       | ({XLEN{f[FN_SLT]}}   & {{(XLEN-1){1'b0}}, lt_s})
                       | ({XLEN{f[FN_SLTU]}}  & {{(XLEN-1){1'b0}}, lt_u})
                       | ({XLEN{f[FN_AND]}}   & and_res)
                       | ({XLEN{f[FN_OR]}}    & or_res)
                       | ({XLEN{f[FN_XOR]}}   & xor_res)
                       | ({XLEN{f[FN_SLL] | f[FN_SRL] | f[FN_SRA]}} & sh_res)
                       | ({XLEN{f[FN_LEA]}}   & lea_res)
                       | ({XLEN{f[FN_BFEXT]}} & bf_res);

endmodule

`default_nettype wire

// ==== hdl/pipe_stage.sv ====
// Single pipeline register with a valid bit over a generic payload type.
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     valid_in,
    input  payload_t data_in,
    output logic     valid_out,
    output payload_t data_out
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
            data_out  <= '0;
        end else begin
            valid_out <= valid_in;
            // the payload holds its value on idle cycles.
            if (valid_in) begin
                data_out <= data_in;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/alu_exec_unit.sv ====
// Execute unit top level with the opcode decoder, two pipe stages and the ALU core.
`timescale 1ns/1ps
`default_nettype none

module alu_exec_unit #(
    parameter bit LEA_EN = 1'b1,
    parameter bit BFO_EN = 1'b1
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  alu_isa_pkg::alu_opcode_t opcode,
    input  alu_defs_pkg::alu_data_t  op_a,
    input  alu_defs_pkg::alu_data_t  op_b,
    output logic                     out_valid,
    output alu_defs_pkg::alu_data_t  result
);
    import alu_defs_pkg::*;

    alu_req_t  req_d;
    alu_req_t  req_q;
    alu_data_t result_next;

    alu_req_if req_bus ();

    alu_op_decode #(.LEA_EN(LEA_EN), .BFO_EN(BFO_EN)) u_decode (
        .opcode (opcode),
        .op_a   (op_a),
        .op_b   (op_b),
        .req    (req_d)
    );

    pipe_stage #(.payload_t(alu_req_t)) stage_dec (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (in_valid),
        .data_in   (req_d),
        .valid_out (req_bus.valid),
        .data_out  (req_q)
    );

    assign req_bus.op_a      = req_q.op_a;
    assign req_bus.op_b      = req_q.op_b;
    assign req_bus.func      = req_q.func;
    assign req_bus.logic_inv = req_q.logic_inv;
    assign req_bus.scale     = req_q.scale;
    assign req_bus.bf_signed = req_q.bf_signed;

    alu_core #(.LEA_EN(LEA_EN), .BFO_EN(BFO_EN)) u_core (
        .req         (req_bus.sink),
        .result_next (result_next)
    );

    pipe_stage #(.payload_t(alu_data_t)) stage_res (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (req_bus.valid),
        .data_in   (result_next),
        .valid_out (out_valid),
        .data_out  (result)
    );

endmodule

`default_nettype wire

// ==== tb/alu_exec_unit_assert.sv ====
// Reference model and concurrent checks for the execute unit, bound to its top level.
`timescale 1ns/1ps
`default_nettype none

module alu_exec_unit_assert (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     in_valid,
    input alu_isa_pkg::alu_opcode_t opcode,
    input alu_defs_pkg::alu_data_t  op_a,
    input alu_defs_pkg::alu_data_t  op_b,
    input logic                     out_valid,
    input alu_defs_pkg::alu_data_t  result
);
    import alu_defs_pkg::*;
    import alu_isa_pkg::*;

    logic [1:0]  v_hist;
    alu_opcode_t op_d1;
    alu_opcode_t op_d2;
    alu_data_t   a_d1;
    alu_data_t   a_d2;
    alu_data_t   b_d1;
    alu_data_t   b_d2;
    alu_data_t   expected;

    function automatic alu_data_t ref_result(input alu_opcode_t op, input alu_data_t a,
                                             input alu_data_t b);
        int        lo;
        int        hi;
        alu_data_t f;
        lo = int'(b[4:0]);
        hi = int'(b[10:6]);
        f  = '0;
        case (op)
            ADD:    f = a + b;
            SUB:    f = a - b;
            SLT:    f = {31'd0, $signed(a) < $signed(b)};
            SLTU:   f = {31'd0, a < b};
            AND:    f = a & b;
            OR:     f = a | b;
            XOR:    f = a ^ b;
            ANDN:   f = a & ~b;
            ORN:    f = a | ~b;
            XNOR:   f = ~(a ^ b);
            SLL:    f = a << b[4:0];
            SRL:    f = a >> b[4:0];
            SRA:    f = $signed(a) >>> b[4:0];
            LEA1:   f = a + {b[30:0], 1'b0};
            LEA2:   f = a + {b[29:0], 2'b0};
            LEA3:   f = a + {b[28:0], 3'b0};
            BFEXTU, BFEXT: begin
                // a field with its high bound below its low bound stays zero.
                for (int i = 0; i < 32 && hi >= lo; i++) begin
                    if (i <= hi - lo) begin
                        f[i] = a[i + lo];
                    end else begin
                        f[i] = (op == BFEXT) & a[hi];
                    end
                end
            end
            default: f = '0;
        endcase
        return f;
    endfunction

    // input history, two edges deep, lines up with the result leaving the unit.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_hist <= '0;
            op_d1  <= ADD;
            op_d2  <= ADD;
            a_d1   <= '0;
            a_d2   <= '0;
            b_d1   <= '0;
            b_d2   <= '0;
        end else begin
            v_hist <= {v_hist[0], in_valid};
            op_d1  <= opcode;
            op_d2  <= op_d1;
            a_d1   <= op_a;
            a_d2   <= a_d1;
            b_d1   <= op_b;
            b_d2   <= b_d1;
        end
    end

    assign expected = ref_result(op_d2, a_d2, b_d2);

    reset_quiet: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> !out_valid)
    else begin
        alu_exec_unit_tb.error_count++;
        $error("Error at %0t: out_valid expected 0 observed %0b", $time, $sampled(out_valid));
    end

    fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == v_hist[1])
    else begin
        alu_exec_unit_tb.error_count++;
        $error("Error at %0t: out_valid expected %0b observed %0b", $time,
               $sampled(v_hist[1]), $sampled(out_valid));
    end

    result_match: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> result == expected)
    else begin
        alu_exec_unit_tb.error_count++;
        $error("Error at %0t: result expected %h observed %h", $time,
               $sampled(expected), $sampled(result));
    end

endmodule

`default_nettype wire

// ==== tb/alu_exec_unit_tb.sv ====
// Testbench for the execute unit with clock, reset, corner and random stimulus, and a watchdog.
`timescale 1ns/1ps
`default_nettype none

module alu_exec_unit_tb;
    import alu_defs_pkg::*;
    import alu_isa_pkg::*;

    localparam int RESET_CYCLES  = 10;
    localparam int SWEEP_ITEMS   = 18 * 16;
    localparam int RANDOM_CYCLES = 600;
    localparam int MARGIN        = 40;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    alu_opcode_t opcode;
    alu_data_t   op_a;
    alu_data_t   op_b;
    logic        out_valid;
    alu_data_t   result;
    logic [31:0] rng_state;
    logic [31:0] a_rnd;
    logic [31:0] b_rnd;
    int          error_count;

    alu_exec_unit #(.LEA_EN(1'b1), .BFO_EN(1'b1)) dut0 (.*);

    bind alu_exec_unit alu_exec_unit_assert u_assert (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // selectors 0 to 2 give zero, all ones and the most negative word.
    function automatic alu_data_t corner_word(input int sel, input logic [31:0] rnd);
        case (sel)
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            default: return rnd;
        endcase
    endfunction

    task automatic drive_item(input logic v, input alu_opcode_t op, input alu_data_t a,
                              input alu_data_t b);
        @(posedge clk);
        #1;
        in_valid = v;
        opcode   = op;
        op_a     = a;
        op_b     = b;
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        // in_valid stays high through reset, so only the reset keeps out_valid low.
        in_valid    = 1'b1;
        opcode      = ADD;
        op_a        = '0;
        op_b        = '0;
        rng_state   = 32'had29;
        error_count = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n    = 1'b1;
        in_valid = 1'b0;
        // every opcode against every pair of corner operands, back to back.
        for (int op = 0; op < 18; op++) begin
            for (int k = 0; k < 16; k++) begin
                rng_state = xorshift32(rng_state);
                drive_item(1'b1, alu_opcode_t'(op[4:0]), corner_word(k % 4, rng_state),
                           corner_word(k / 4, ~rng_state));
            end
        end
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            rng_state = xorshift32(rng_state);
            a_rnd     = rng_state;
            rng_state = xorshift32(rng_state);
            b_rnd     = rng_state;
            // pin the shift amount to 0 or 31 now and then.
            if (a_rnd[7:6] == 2'b00) begin
                b_rnd[4:0] = {5{a_rnd[8]}};
            end
            drive_item(a_rnd[3:0] != 4'd0, alu_opcode_t'(5'(a_rnd[31:16] % 16'd18)),
                       corner_word(int'(a_rnd[11:9]), a_rnd), b_rnd);
        end
        drive_item(1'b0, ADD, '0, '0);
        repeat (4) @(posedge clk);
        $display("closing report: %0d errors", error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #((RESET_CYCLES + SWEEP_ITEMS + RANDOM_CYCLES + MARGIN) * 10);
        $display("Timeout: the stimulus did not finish within the expected number of cycles.");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== alu_exec_unit.f ====
hdl/alu_defs_pkg.sv
hdl/alu_isa_pkg.sv
hdl/alu_req_if.sv
hdl/alu_op_decode.sv
hdl/alu_core.sv
hdl/pipe_stage.sv
hdl/alu_exec_unit.sv
tb/alu_exec_unit_assert.sv
tb/alu_exec_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the execute unit testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module alu_exec_unit_tb \
    -f alu_exec_unit.f -o alu_exec_unit_sim
./obj_dir/alu_exec_unit_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
echo "run did not report a pass"
exit 1
